// ==== hdl/quad_pkg.sv ====
package quad_pkg;

    // coefficients b and c, signed Q1.7
    localparam int COEF_W    = 8;
    localparam int COEF_FRAC = 7;

    // b squared, Q2.14 and never negative
    localparam int SQ_W      = 16;

    // discriminant on the same 2^-14 grid as b squared
    localparam int DISC_W    = 18;
    localparam int RAD_W     = 18;

    // square root and roots, 7 fractional bits
    localparam int ROOT_W    = 9;

    // pipeline depths
    localparam int SQ_LAT    = 2;
    localparam int SQRT_LAT  = 9;
    localparam int QR_LAT    = 13;

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic        [SQ_W-1:0]   square_t;
    typedef logic signed [DISC_W-1:0] disc_t;
    typedef logic        [RAD_W-1:0]  radicand_t;

    // unsigned square root and the signed roots share one width
    typedef logic        [ROOT_W-1:0] sroot_t;
    typedef logic signed [ROOT_W-1:0] root_t;

endpackage

// ==== hdl/quad_ifs.sv ====
// path from the top level to the b squarer
interface square_if
    import quad_pkg::*;
();

    logic    in_valid;
    coef_t   operand;
    logic    out_valid;
    square_t square;

    modport client (
        output in_valid,
        output operand,
        input  out_valid,
        input  square
    );

    modport server (
        input  in_valid,
        input  operand,
        output out_valid,
        output square
    );

endinterface

// path from the top level to the square root pipeline
interface sqrt_if
    import quad_pkg::*;
();

    logic      in_valid;
    radicand_t radicand;
    logic      out_valid;
    sroot_t    root;

    modport client (
        output in_valid,
        output radicand,
        input  out_valid,
        input  root
    );

    modport server (
        input  in_valid,
        input  radicand,
        output out_valid,
        output root
    );

endinterface

// ==== hdl/fix_square.sv ====
module fix_square
    import quad_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    square_if.server sq
);

    // stage 1, operand register
    coef_t   op_q;
    logic    op_vld_q;

    // stage 2, product register
    square_t sq_q;
    logic    sq_vld_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_vld_q <= 1'b0;
            sq_vld_q <= 1'b0;
        end else begin
            op_vld_q <= sq.in_valid;
            sq_vld_q <= op_vld_q;
        end
    end

    // signed product, widened to 16 bits by the assignment context
    // (-128)^2 is 0x4000, so the result always fits unsigned
    always_ff @(posedge clk) begin
        op_q <= sq.operand;
        sq_q <= op_q * op_q;
    end

    assign sq.out_valid = sq_vld_q;
    assign sq.square    = sq_q;

endmodule

// ==== hdl/isqrt_pipe.sv ====
module isqrt_pipe
    import quad_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    sqrt_if.server sr
);

    // per stage inputs, stage 0 is fed from the interface
    radicand_t rem_in  [SQRT_LAT];
    sroot_t    root_in [SQRT_LAT];

    // growth of root^2 if the stage bit gets set
    radicand_t trial   [SQRT_LAT];
    logic [SQRT_LAT-1:0] fits;

    // stage registers
    // the last stage has no use for its remainder
    radicand_t rem_q   [SQRT_LAT-1];
    sroot_t    root_q  [SQRT_LAT];
    logic [SQRT_LAT-1:0] vld_q;

    // valid walks down the stages one per clock
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[SQRT_LAT-2:0], sr.in_valid};
        end
    end

    for (genvar s = 0; s < SQRT_LAT; s++) begin : g_stage

        if (s == 0) begin : g_head
            // nothing decided yet, remainder is the whole radicand
            assign rem_in[s]  = sr.radicand;
            assign root_in[s] = '0;
        end else begin : g_body
            assign rem_in[s]  = rem_q[s-1];
            assign root_in[s] = root_q[s-1];
        end

        // stage s decides bit k = ROOT_W-1-s
        // (r + 2^k)^2 - r^2 = r*2^(k+1) + 2^(2k)
        // r only holds bits above k, so the sum stays below 2^18
        assign trial[s] = (radicand_t'(root_in[s]) << (ROOT_W - s))
                        + (radicand_t'(1) << (2 * (ROOT_W - 1 - s)));

        // keep the bit when the trial square still fits in the remainder
        assign fits[s] = (trial[s] <= rem_in[s]);

        always_ff @(posedge clk) begin
            if (fits[s]) begin
                root_q[s] <= root_in[s] | (sroot_t'(1) << (ROOT_W - 1 - s));
            end else begin
                root_q[s] <= root_in[s];
            end
        end

        if (s < SQRT_LAT - 1) begin : g_rem
            always_ff @(posedge clk) begin
                if (fits[s]) begin
                    rem_q[s] <= rem_in[s] - trial[s];
                end else begin
                    rem_q[s] <= rem_in[s];
                end
            end
        end

    end

    // floor(sqrt(radicand)) after the last stage
    assign sr.root      = root_q[SQRT_LAT-1];
    assign sr.out_valid = vld_q[SQRT_LAT-1];

endmodule

// ==== hdl/quad_root.sv ====
module quad_root
    import quad_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,

    input  logic  din_valid,
    input  coef_t b,
    input  coef_t c,

    output logic  dout_valid,
    output root_t x1,
    output root_t x2,
    output logic  no_real
);

    square_if sq_bus ();
    sqrt_if   sr_bus ();

    // b squared, SQ_LAT cycles
    assign sq_bus.in_valid = din_valid;
    assign sq_bus.operand  = b;

    fix_square u_square (
        .clk   (clk),
        .rst_n (rst_n),
        .sq    (sq_bus.server)
    );

    // b and c wait for the squarer
    coef_t b_dly [SQ_LAT];
    coef_t c_dly [SQ_LAT];

    always_ff @(posedge clk) begin
        b_dly[0] <= b;
        c_dly[0] <= c;
        for (int i = 1; i < SQ_LAT; i++) begin
            b_dly[i] <= b_dly[i-1];
            c_dly[i] <= c_dly[i-1];
        end
    end

    // discriminant stage
    disc_t disc_d;
    disc_t disc_q;
    logic  neg_q;
    logic  disc_vld_q;
    coef_t b_disc_q;

    // 4c put on the 2^-14 grid of b^2, i.e. 512*c in integer units
    assign disc_d = disc_t'(sq_bus.square)
                  - (disc_t'(c_dly[SQ_LAT-1]) <<< (COEF_FRAC + 2));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disc_vld_q <= 1'b0;
        end else begin
            disc_vld_q <= sq_bus.out_valid;
        end
    end

    always_ff @(posedge clk) begin
        disc_q   <= disc_d;
        neg_q    <= disc_d[DISC_W-1];
        b_disc_q <= b_dly[SQ_LAT-1];
    end

    // negative discriminant gives a zero radicand, the flag carries the news
    assign sr_bus.in_valid = disc_vld_q;
    assign sr_bus.radicand = neg_q ? '0 : radicand_t'(disc_q);

    isqrt_pipe u_sqrt (
        .clk   (clk),
        .rst_n (rst_n),
        .sr    (sr_bus.server)
    );

    // b and the sign flag ride alongside the square root
    coef_t               b_pipe [SQRT_LAT];
    logic [SQRT_LAT-1:0] neg_pipe;

    always_ff @(posedge clk) begin
        b_pipe[0] <= b_disc_q;
        for (int i = 1; i < SQRT_LAT; i++) begin
            b_pipe[i] <= b_pipe[i-1];
        end
        neg_pipe <= {neg_pipe[SQRT_LAT-2:0], neg_q};
    end

    // root combine, one extra bit so -b +/- sqrt(D) cannot wrap
    logic signed [ROOT_W:0] b_ext;
    logic signed [ROOT_W:0] s_ext;
    logic signed [ROOT_W:0] sum_p;
    logic signed [ROOT_W:0] sum_m;

    // b is Q1.7 and the root has 7 fractional bits too, no realignment
    assign b_ext = b_pipe[SQRT_LAT-1];
    assign s_ext = {1'b0, sr_bus.root};
    assign sum_p = s_ext - b_ext;
    assign sum_m = -(b_ext + s_ext);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= sr_bus.out_valid;
        end
    end

    // halving by arithmetic shift, which rounds toward minus infinity
    always_ff @(posedge clk) begin
        no_real <= neg_pipe[SQRT_LAT-1];
        if (neg_pipe[SQRT_LAT-1]) begin
            x1 <= '0;
            x2 <= '0;
        end else begin
            x1 <= root_t'(sum_p >>> 1);
            x2 <= root_t'(sum_m >>> 1);
        end
    end

endmodule

// ==== testbench/tb_quad_root.sv ====
module tb_quad_root
    import quad_pkg::*;
();

    localparam int    CLK_PERIOD  = 8;
    localparam int    RST_CYCLES  = 16;
    localparam int    IDLE_CYCLES = 4;
    localparam int    N_CASES     = 40;
    localparam int    N_RAND      = 400;
    localparam int    RAND_SEED   = 27407;
    localparam string CASE_FILE   = "testbench/quad_cases.txt";

    // every phase plus some slack
    localparam int WATCHDOG_CYCLES =
        RST_CYCLES + IDLE_CYCLES + N_CASES + N_RAND + QR_LAT + 32;

    logic  clk;
    logic  rst_n;
    logic  din_valid;
    coef_t b;
    coef_t c;
    logic  dout_valid;
    root_t x1;
    root_t x2;
    logic  no_real;

    // five words per row for b, c, x1, x2 and no_real
    logic [8:0] case_mem [0:5*N_CASES-1];

    // expected results in input order
    root_t exp_x1_q [$];
    root_t exp_x2_q [$];
    logic  exp_nr_q [$];
    string name_q   [$];

    int cyc = 0;
    int value_errs = 0;
    int other_errs = 0;
    int n_in = 0;
    int n_out = 0;
    int first_in_cyc = 0;
    bit first_out_seen = 1'b0;

    quad_root DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .din_valid  (din_valid),
        .b          (b),
        .c          (c),
        .dout_valid (dout_valid),
        .x1         (x1),
        .x2         (x2),
        .no_real    (no_real)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // rising edges seen so far
    always @(posedge clk) cyc <= cyc + 1;

    // floor(sqrt(d)) by plain search
    function automatic int int_sqrt(input int d);
        int s;
        s = 0;
        while ((s + 1) * (s + 1) <= d) begin
            s++;
        end
        return s;
    endfunction

    // halve and round toward minus infinity
    function automatic int floor_half(input int n);
        if (n >= 0) begin
            return n / 2;
        end
        return -((1 - n) / 2);
    endfunction

    // integer reference model with b and c in units of 2^-7
    task automatic model_roots(input int bv, input int cv,
                               output root_t e1, output root_t e2, output logic nr);
        int d;
        int s;
        d = bv * bv - 512 * cv;
        if (d < 0) begin
            nr = 1'b1;
            e1 = '0;
            e2 = '0;
        end else begin
            s  = int_sqrt(d);
            nr = 1'b0;
            e1 = root_t'(floor_half(s - bv));
            e2 = root_t'(floor_half(-bv - s));
        end
    endtask

    // called on a falling edge
    task automatic send_pair(input coef_t bv, input coef_t cv, input root_t e1,
                             input root_t e2, input logic nr, input string name);
        din_valid = 1'b1;
        b = bv;
        c = cv;
        exp_x1_q.push_back(e1);
        exp_x2_q.push_back(e2);
        exp_nr_q.push_back(nr);
        name_q.push_back(name);
        if (n_in == 0) begin
            first_in_cyc = cyc;
        end
        n_in++;
    endtask

    task automatic check_output();
        root_t e1;
        root_t e2;
        logic  enr;
        string name;
        n_out++;
        if (!first_out_seen && n_in > 0) begin
            first_out_seen = 1'b1;
            assert (cyc - first_in_cyc == QR_LAT) else begin
                $display("first result came %0d cycles after the first input instead of %0d",
                         cyc - first_in_cyc, QR_LAT);
                other_errs++;
            end
        end
        assert (exp_x1_q.size() != 0) else begin
            $display("result at cycle %0d with no input waiting for it", cyc);
            other_errs++;
        end
        if (exp_x1_q.size() != 0) begin
            e1   = exp_x1_q.pop_front();
            e2   = exp_x2_q.pop_front();
            enr  = exp_nr_q.pop_front();
            name = name_q.pop_front();
            assert (no_real === enr) else begin
                $display("[FAIL] %s no_real expected %0d actual %0d", name, enr, no_real);
                value_errs++;
            end
            assert (x1 === e1) else begin
                $display("[FAIL] %s x1 expected %0d actual %0d", name, e1, x1);
                value_errs++;
            end
            assert (x2 === e2) else begin
                $display("[FAIL] %s x2 expected %0d actual %0d", name, e2, x2);
                value_errs++;
            end
        end
    endtask

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        if (dout_valid === 1'b1) begin
            check_output();
        end else begin
            assert (dout_valid === 1'b0) else begin
                $display("dout_valid is unknown at cycle %0d", cyc);
                other_errs++;
            end
        end
    end

    initial begin
        root_t e1;
        root_t e2;
        logic  enr;
        coef_t rb;
        coef_t rc;
        rst_n     = 1'b0;
        din_valid = 1'b0;
        b         = '0;
        c         = '0;
        void'($urandom(RAND_SEED));

        // rows missing from the file keep an impossible no_real
        for (int i = 0; i < 5 * N_CASES; i++) begin
            case_mem[i] = '1;
        end
        $readmemh(CASE_FILE, case_mem);
        assert (case_mem[5*N_CASES-1] <= 9'd1) else begin
            $display("case file holds fewer than %0d rows", N_CASES);
            other_errs++;
        end

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // nothing may come out before the first input
        repeat (IDLE_CYCLES) @(negedge clk);

        // directed cases back to back
        for (int i = 0; i < N_CASES; i++) begin
            send_pair(coef_t'(case_mem[5*i]), coef_t'(case_mem[5*i+1]),
                      root_t'(case_mem[5*i+2]), root_t'(case_mem[5*i+3]),
                      case_mem[5*i+4][0], $sformatf("case %0d", i));
            @(negedge clk);
        end

        // random pairs with random gaps
        for (int i = 0; i < N_RAND; i++) begin
            if ($urandom_range(3) != 0) begin
                rb = coef_t'($urandom);
                rc = coef_t'($urandom);
                model_roots(int'(rb), int'(rc), e1, e2, enr);
                send_pair(rb, rc, e1, e2, enr, $sformatf("rand %0d", i));
            end else begin
                din_valid = 1'b0;
            end
            @(negedge clk);
        end
        din_valid = 1'b0;

        // drain, then watch for stray results
        while (exp_x1_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (QR_LAT + 2) @(negedge clk);

        assert (n_out == n_in) else begin
            $display("%0d inputs were accepted but %0d results came out", n_in, n_out);
            other_errs++;
        end

        $display("%0d inputs, %0d results, %0d value errors, %0d other errors",
                 n_in, n_out, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles with %0d results still outstanding",
                 WATCHDOG_CYCLES, exp_x1_q.size());
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== quad_root.f ====
hdl/quad_pkg.sv
hdl/quad_ifs.sv
hdl/fix_square.sv
hdl/isqrt_pipe.sv
hdl/quad_root.sv
testbench/tb_quad_root.sv

// ==== Makefile ====
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_quad_root
FILELIST := quad_root.f
OBJ_DIR  := obj_dir
PASS_MSG := >>> PASS

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/quad_cases.txt ====
// directed cases for quad_root, one per line, all values in hex
// b  c  x1  x2  no_real   (b, c signed Q1.7; x1, x2 signed Q2.7 in 9 bits)
00 00 000 000 0
00 80 080 180 0
00 E0 040 1C0 0
00 FF 00B 1F5 0
00 FE 010 1F0 0
00 20 000 000 1
00 01 000 000 1
// double roots
80 20 040 040 0
40 08 1E0 1E0 0
// extreme coefficients
80 80 0CF 1B1 0
7F 80 04F 132 0
7F 7F 000 000 1
80 7F 000 000 1
80 00 080 000 0
7F 00 000 181 0
7F FF 001 180 0
80 FF 080 1FF 0
FE 81 080 181 0
// small b, odd sums round down
01 00 000 1FF 0
FF 00 001 000 0
03 00 000 1FD 0
05 FD 011 1EA 0
F9 02 000 000 1
F9 FE 013 1F3 0
02 01 000 000 1
// exact roots
C0 C0 080 1C0 0
40 C0 040 180 0
20 F0 020 1C0 0
A0 10 040 020 0
60 10 1E0 1C0 0
// around D = 0
40 10 000 000 1
80 21 000 000 1
80 1F 04B 035 0
CE 05 000 000 1
CE 04 023 00E 0
7F 20 000 000 1
// mixed
64 9C 049 152 0
9C 32 000 000 1
9C CE 090 1D4 0
11 B3 05B 194 0
